//--- filelist.f
+incdir+include
src/cpu_pkg.sv
src/cpu_host_ctrl.sv
src/cpu_fetch.sv
src/cpu_hazard.sv
src/cpu_decode.sv
src/cpu_execute.sv
src/cpu_mem_stage.sv
src/cpu_top.sv
testbench/cpu_tb.sv

//--- include/cpu_defs.svh
// cpu defines: widths, memory depths, host address map of the pipelined core
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define XLEN         32
`define ADDR_W       16
`define REG_SEL_W    4       // 16 registers

// loader word counts, one word per memory entry
`define IMEM_WORDS   64
`define DMEM_WORDS   64

////////////////////////////////////////
// host address map
////////////////////////////////////////
`define DM_LOAD_BASE 16'h1000 // data word k requested at base + 4k
`define HOST_BASE    16'h9000 // stores at or above go to the host

`endif

//--- src/cpu_decode.sv
// decode stage: control decode, 16-entry register file and the ID/EX register
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              core_hold,
    input  cpu_pkg::if_id_t   if_id,
    input  cpu_pkg::mem_wb_t  mem_wb,
    output cpu_pkg::id_ex_t   id_ex
);

    logic [`XLEN-1:0]      regs [0:(1 << `REG_SEL_W)-1];
    cpu_pkg::ctrl_t        ctrl;
    logic [`REG_SEL_W-1:0] sel1, sel2;
    logic [`XLEN-1:0]      imm_ext;

    assign ctrl    = cpu_pkg::decode_ctrl(if_id.instr[31:24]);
    assign sel1    = if_id.instr[19:16];
    assign sel2    = cpu_pkg::uses_rd(if_id.instr[31:24]) ? if_id.instr[23:20]
                                                          : if_id.instr[15:12];
    assign imm_ext = {{(`XLEN-16){if_id.instr[15]}}, if_id.instr[15:0]};

    ////////////////////////////////////////
    // register file, written from writeback
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `REG_SEL_W); i++) begin
                regs[i] <= '0;
            end
        end else if (mem_wb.reg_wr) begin
            regs[mem_wb.rd] <= mem_wb.wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!core_hold) begin  // frozen while the host write is open
            id_ex.ctrl <= ctrl;
            id_ex.val1 <= regs[sel1];
            id_ex.val2 <= regs[sel2];
            id_ex.imm  <= imm_ext;
            id_ex.rd   <= if_id.instr[23:20];
        end
    end

endmodule

//--- src/cpu_execute.sv
// execute stage: ALU, branch compare, store routing and the EX/MEM register
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 core_hold,
    input  cpu_pkg::id_ex_t      id_ex,
    output cpu_pkg::ex_mem_t     ex_mem,
    output cpu_pkg::store_req_t  store_req,
    output logic                 branch_taken,
    output logic [`ADDR_W-1:0]   branch_target
);

    logic [`XLEN-1:0] opb;
    logic [`XLEN-1:0] alu;
    logic             taken;

    assign opb = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.val2;

    always_comb begin
        case (id_ex.ctrl.op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI,
            cpu_pkg::OP_LD, cpu_pkg::OP_ST: alu = id_ex.val1 + opb; // ld/st address too
            cpu_pkg::OP_SUB: alu = id_ex.val1 - opb;
            cpu_pkg::OP_AND: alu = id_ex.val1 & opb;
            cpu_pkg::OP_OR:  alu = id_ex.val1 | opb;
            cpu_pkg::OP_XOR: alu = id_ex.val1 ^ opb;
            default:         alu = '0;
        endcase
    end

    ////////////////////////////////////////
    // branch resolution
    ////////////////////////////////////////
    always_comb begin
        case (id_ex.ctrl.op)
            cpu_pkg::OP_BEQ: taken = (id_ex.val1 == id_ex.val2);
            cpu_pkg::OP_BNE: taken = (id_ex.val1 != id_ex.val2);
            cpu_pkg::OP_JMP: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign branch_taken  = taken && !core_hold;
    assign branch_target = id_ex.imm[`ADDR_W-1:0]; // absolute byte address

    always_comb begin
        store_req.valid = id_ex.ctrl.mem_wr && !core_hold;
        store_req.addr  = alu[`ADDR_W-1:0];
        store_req.data  = id_ex.val2;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (core_hold) begin
            ex_mem <= '0;           // bubble while the host write drains
        end else begin
            ex_mem.ctrl    <= id_ex.ctrl;
            ex_mem.alu_res <= alu;
            ex_mem.rd      <= id_ex.rd;
        end
    end

endmodule

//--- src/cpu_fetch.sv
// fetch stage: pc, loader-written instruction memory and the IF/ID register
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                core_hold,
    input  logic                stall,
    input  logic                branch_taken,
    input  logic [`ADDR_W-1:0]  branch_target,
    input  cpu_pkg::load_wr_t   load_wr,
    output logic [`XLEN-1:0]    if_word,
    output cpu_pkg::if_id_t     if_id
);

    localparam int IM_IDX_W = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0]   imem [0:`IMEM_WORDS-1];
    logic [`ADDR_W-1:0] pc;

    always_ff @(posedge clk) begin
        if (load_wr.valid && !load_wr.to_dmem) begin
            imem[load_wr.idx[IM_IDX_W-1:0]] <= load_wr.data;
        end
    end

    assign if_word = imem[pc[IM_IDX_W+1:2]]; // word addressed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!(stall || core_hold)) begin
            pc <= pc + `ADDR_W'd4;
        end
    end

    // reset nop stays put through loading, held instr waits out a host write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (!core_hold) begin
            if (stall) begin
                if_id <= '0;            // injected nop
            end else begin
                if_id.instr <= if_word;
                if_id.pc    <= pc;
            end
        end
    end

endmodule

//--- src/cpu_hazard.sv
// hazard unit: read-after-write and jump/branch stalls, no forwarding
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_hazard (
    input  logic [`XLEN-1:0]  if_word,
    input  cpu_pkg::if_id_t   if_id,
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::ex_mem_t  ex_mem,
    input  cpu_pkg::mem_wb_t  mem_wb,
    output logic              stall
);

    cpu_pkg::ctrl_t        dec_ctrl;  // instr sitting in decode
    logic [7:0]            code;
    logic [`REG_SEL_W-1:0] src1, src2;
    logic                  use1, use2;
    logic [3:0]            wr_en;
    logic [`REG_SEL_W-1:0] wr_rd [4];
    logic                  raw, jb;

    assign dec_ctrl = cpu_pkg::decode_ctrl(if_id.instr[31:24]);
    assign code     = if_word[31:24];
    assign src1     = if_word[19:16];
    assign src2     = cpu_pkg::uses_rd(code) ? if_word[23:20] : if_word[15:12];

    always_comb begin
        use1 = 1'b0;
        use2 = cpu_pkg::uses_rd(code);
        case (code)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
            cpu_pkg::OP_OR, cpu_pkg::OP_XOR: begin
                use1 = 1'b1;
                use2 = 1'b1;
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_LD, cpu_pkg::OP_ST,
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
                use1 = 1'b1;
            end
            default: ;
        endcase
    end

    // pending writes, decode down to writeback
    assign wr_en = {dec_ctrl.reg_wr, id_ex.ctrl.reg_wr, ex_mem.ctrl.reg_wr, mem_wb.reg_wr};
    assign wr_rd[3] = if_id.instr[23:20];
    assign wr_rd[2] = id_ex.rd;
    assign wr_rd[1] = ex_mem.rd;
    assign wr_rd[0] = mem_wb.rd;

    always_comb begin
        raw = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (wr_en[i] && ((use1 && wr_rd[i] == src1) || (use2 && wr_rd[i] == src2))) begin
                raw = 1'b1;
            end
        end
    end

    assign jb    = dec_ctrl.is_branch || id_ex.ctrl.is_branch; // resolved in execute
    assign stall = raw || jb;

endmodule

//--- src/cpu_host_ctrl.sv
// host controller: linear program/data loader and held host-write FSM
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_host_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ready,
    input  logic                 rd_valid,
    input  logic                 tx_done,
    input  logic [`XLEN-1:0]     ex_wrt_data,
    input  cpu_pkg::store_req_t  store_req,
    output cpu_pkg::host_op_t    op,
    output logic [`ADDR_W-1:0]   ex_addr,
    output logic [`XLEN-1:0]     ex_rd_data,
    output cpu_pkg::load_wr_t    load_wr,
    output logic                 core_hold
);

    cpu_pkg::host_state_t state, state_nxt;
    logic [`ADDR_W-3:0]   cnt;       // word within current block
    logic [`ADDR_W-1:0]   wr_addr;
    logic [`XLEN-1:0]     wr_data;
    logic                 last_word;
    logic                 host_store;

    assign host_store = store_req.valid && (store_req.addr >= `HOST_BASE);
    assign last_word  = (state == cpu_pkg::ST_LOAD_IM) ? (cnt == `IMEM_WORDS - 1)
                                                       : (cnt == `DMEM_WORDS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::ST_IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            if (load_wr.valid) begin
                cnt <= last_word ? '0 : cnt + 1'b1; // restart for the next block
            end
        end
    end

    // store address/data held for the host until tx_done
    always_ff @(posedge clk) begin
        if ((state == cpu_pkg::ST_RUN) && host_store) begin
            wr_addr <= store_req.addr;
            wr_data <= store_req.data;
        end
    end

    ////////////////////////////////////////
    // next state and host port
    ////////////////////////////////////////
    always_comb begin
        state_nxt       = state;
        op              = cpu_pkg::HOST_IDLE;
        ex_addr         = '0;
        ex_rd_data      = '0;
        load_wr         = '0;
        load_wr.idx     = cnt;
        load_wr.data    = ex_wrt_data;
        core_hold       = 1'b1;
        case (state)
            cpu_pkg::ST_IDLE: begin
                if (ready) begin
                    state_nxt = cpu_pkg::ST_LOAD_IM;
                end
            end
            cpu_pkg::ST_LOAD_IM: begin
                op            = cpu_pkg::HOST_READ;
                ex_addr       = {cnt, 2'b00};
                load_wr.valid = rd_valid;
                if (rd_valid && last_word) begin
                    state_nxt = cpu_pkg::ST_LOAD_DM;
                end
            end
            cpu_pkg::ST_LOAD_DM: begin
                op              = cpu_pkg::HOST_READ;
                ex_addr         = `DM_LOAD_BASE + {cnt, 2'b00};
                load_wr.valid   = rd_valid;
                load_wr.to_dmem = 1'b1;
                if (rd_valid && last_word) begin
                    state_nxt = cpu_pkg::ST_RUN;
                end
            end
            cpu_pkg::ST_RUN: begin
                core_hold = 1'b0;
                if (host_store) begin
                    state_nxt = cpu_pkg::ST_WRT_HOST;
                end
            end
            cpu_pkg::ST_WRT_HOST: begin
                op         = cpu_pkg::HOST_WRITE;
                ex_addr    = wr_addr;
                ex_rd_data = wr_data;
                if (tx_done) begin
                    state_nxt = cpu_pkg::ST_RUN;
                end
            end
            default: begin
                state_nxt = cpu_pkg::ST_IDLE;
            end
        endcase
    end

endmodule

//--- src/cpu_mem_stage.sv
// memory stage: data memory and the MEM/WB register with writeback select
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::ex_mem_t  ex_mem,
    input  logic [`XLEN-1:0]  store_data,
    input  cpu_pkg::load_wr_t load_wr,
    output cpu_pkg::mem_wb_t  mem_wb
);

    localparam int DM_IDX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]    dmem [0:`DMEM_WORDS-1];
    logic [`XLEN-1:0]    st_data_q;
    logic [`XLEN-1:0]    rd_data;
    logic [DM_IDX_W-1:0] idx;
    logic                local_st;

    assign idx      = ex_mem.alu_res[DM_IDX_W+1:2];
    assign local_st = ex_mem.ctrl.mem_wr && (ex_mem.alu_res[`ADDR_W-1:0] < `HOST_BASE);

    // store data leaves execute one cycle ahead, lines up with ex_mem
    always_ff @(posedge clk) begin
        st_data_q <= store_data;
    end

    always_ff @(posedge clk) begin
        if (load_wr.valid && load_wr.to_dmem) begin
            dmem[load_wr.idx[DM_IDX_W-1:0]] <= load_wr.data;
        end else if (local_st) begin
            dmem[idx] <= st_data_q;
        end
    end

    assign rd_data = ex_mem.ctrl.mem_rd ? dmem[idx] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_wr  <= ex_mem.ctrl.reg_wr;
            mem_wb.rd      <= ex_mem.rd;
            mem_wb.wb_data <= ex_mem.ctrl.mem_to_reg ? rd_data : ex_mem.alu_res;
        end
    end

endmodule

//--- src/cpu_pkg.sv
// cpu types: opcodes, host ops, loader states and pipeline register layouts
`include "cpu_defs.svh"

package cpu_pkg;

    // fields: opcode [31:24], rd [23:20], rs [19:16], rt [15:12], imm [15:0]
    // st writes rd to mem[rs+imm], beq/bne compare rs with rd
    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h01,
        OP_SUB  = 8'h02,
        OP_AND  = 8'h03,
        OP_OR   = 8'h04,
        OP_XOR  = 8'h05,
        OP_ADDI = 8'h09,
        OP_BEQ  = 8'h31,
        OP_BNE  = 8'h33,
        OP_JMP  = 8'h3D,
        OP_LD   = 8'h81,
        OP_ST   = 8'h83
    } opcode_t;

    typedef enum logic [1:0] {
        HOST_IDLE  = 2'b00,
        HOST_READ  = 2'b01,
        HOST_WRITE = 2'b11
    } host_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_IM,
        ST_LOAD_DM,
        ST_RUN,
        ST_WRT_HOST
    } host_state_t;

    ////////////////////////////////////////
    // pipeline registers
    ////////////////////////////////////////
    typedef struct packed {
        opcode_t op;
        logic    use_imm;
        logic    reg_wr;
        logic    mem_rd;
        logic    mem_wr;
        logic    mem_to_reg;
        logic    is_branch;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0]   instr;
        logic [`ADDR_W-1:0] pc;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`XLEN-1:0]      val1;  // rs
        logic [`XLEN-1:0]      val2;  // rt, or rd for st/beq/bne
        logic [`XLEN-1:0]      imm;
        logic [`REG_SEL_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`XLEN-1:0]      alu_res;
        logic [`REG_SEL_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_wr;
        logic [`REG_SEL_W-1:0] rd;
        logic [`XLEN-1:0]      wb_data;
    } mem_wb_t;

    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] addr;
        logic [`XLEN-1:0]   data;
    } store_req_t;

    typedef struct packed {
        logic               valid;
        logic               to_dmem;  // 0 = instruction memory
        logic [`ADDR_W-3:0] idx;
        logic [`XLEN-1:0]   data;
    } load_wr_t;

    // control fields for one opcode
    function automatic ctrl_t decode_ctrl(input logic [7:0] code);
        ctrl_t c;
        c = '0;
        c.op = opcode_t'(code);
        case (code)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                c.reg_wr = 1'b1;
            end
            OP_ADDI: begin
                c.use_imm = 1'b1;
                c.reg_wr  = 1'b1;
            end
            OP_LD: begin
                c.use_imm    = 1'b1;
                c.reg_wr     = 1'b1;
                c.mem_rd     = 1'b1;
                c.mem_to_reg = 1'b1;
            end
            OP_ST: begin
                c.use_imm = 1'b1;
                c.mem_wr  = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_JMP: begin
                c.is_branch = 1'b1;
            end
            default: begin
                c.op = OP_NOP; // unknown codes run as nop
            end
        endcase
        return c;
    endfunction

    // second source taken from the rd field
    function automatic logic uses_rd(input logic [7:0] code);
        return (code == OP_ST) || (code == OP_BEQ) || (code == OP_BNE);
    endfunction

endpackage

//--- src/cpu_top.sv
// cpu top: five-stage pipelined core with its host loader and write port
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ready,
    input  logic                 rd_valid,
    input  logic                 tx_done,
    input  logic [`XLEN-1:0]     ex_wrt_data,
    output cpu_pkg::host_op_t    op,
    output logic [`ADDR_W-1:0]   ex_addr,
    output logic [`XLEN-1:0]     ex_rd_data
);

    cpu_pkg::load_wr_t   load_wr;
    cpu_pkg::store_req_t store_req;
    cpu_pkg::if_id_t     if_id;
    cpu_pkg::id_ex_t     id_ex;
    cpu_pkg::ex_mem_t    ex_mem;
    cpu_pkg::mem_wb_t    mem_wb;
    logic [`XLEN-1:0]    if_word;
    logic [`ADDR_W-1:0]  branch_target;
    logic                branch_taken;
    logic                core_hold;
    logic                stall;

    cpu_host_ctrl u_host_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .ready       (ready),
        .rd_valid    (rd_valid),
        .tx_done     (tx_done),
        .ex_wrt_data (ex_wrt_data),
        .store_req   (store_req),
        .op          (op),
        .ex_addr     (ex_addr),
        .ex_rd_data  (ex_rd_data),
        .load_wr     (load_wr),
        .core_hold   (core_hold)
    );

    cpu_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_hold     (core_hold),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .load_wr       (load_wr),
        .if_word       (if_word),
        .if_id         (if_id)
    );

    cpu_hazard u_hazard (
        .if_word (if_word),
        .if_id   (if_id),
        .id_ex   (id_ex),
        .ex_mem  (ex_mem),
        .mem_wb  (mem_wb),
        .stall   (stall)
    );

    cpu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .core_hold (core_hold),
        .if_id     (if_id),
        .mem_wb    (mem_wb),
        .id_ex     (id_ex)
    );

    cpu_execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_hold     (core_hold),
        .id_ex         (id_ex),
        .ex_mem        (ex_mem),
        .store_req     (store_req),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    cpu_mem_stage u_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .store_data (store_req.data),
        .load_wr    (load_wr),
        .mem_wb     (mem_wb)
    );

endmodule

//--- testbench/cpu_tb.sv
// cpu testbench with a host model for the loader and host writes, a program table and checks
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_tb;

    localparam int NUM_PROGS   = 4;
    localparam int MAX_WR      = 16;
    localparam int CYCLE_LIMIT = NUM_PROGS * (128 * 4 + 400);

    logic               clk = 1'b0;
    logic               rst_n;
    logic               ready;
    logic               rd_valid;
    logic               tx_done;
    logic [`XLEN-1:0]   ex_wrt_data;
    cpu_pkg::host_op_t  op;
    logic [`ADDR_W-1:0] ex_addr;
    logic [`XLEN-1:0]   ex_rd_data;

    // one entry per program with images and expected host writes in order
    logic [`XLEN-1:0]   im_tab      [NUM_PROGS][`IMEM_WORDS];
    logic [`XLEN-1:0]   dm_tab      [NUM_PROGS][`DMEM_WORDS];
    logic [`ADDR_W-1:0] wr_addr_tab [NUM_PROGS][MAX_WR];
    logic [`XLEN-1:0]   wr_data_tab [NUM_PROGS][MAX_WR];
    int                 im_len      [NUM_PROGS];
    int                 wr_cnt      [NUM_PROGS];
    int                 cycle_cnt   = 0;

    cpu_top u_cpu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .ready       (ready),
        .rd_valid    (rd_valid),
        .tx_done     (tx_done),
        .ex_wrt_data (ex_wrt_data),
        .op          (op),
        .ex_addr     (ex_addr),
        .ex_rd_data  (ex_rd_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        abort_run($sformatf("error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    ////////////////////////////////////////
    // instruction and table helpers
    ////////////////////////////////////////
    function automatic logic [31:0] alu_word(input cpu_pkg::opcode_t opc, input logic [3:0] rd,
                                             input logic [3:0] rs, input logic [3:0] rt);
        return {opc, rd, rs, rt, 12'h000};
    endfunction

    function automatic logic [31:0] imm_word(input cpu_pkg::opcode_t opc, input logic [3:0] rd,
                                             input logic [3:0] rs, input logic [15:0] imm);
        return {opc, rd, rs, imm};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [15:0] host_addr(input int k);
        return 16'(`HOST_BASE + 4 * k);
    endfunction

    // data preload word whose low half is its own host address
    function automatic logic [31:0] fill_word(input int p, input int k);
        logic [15:0] addr;
        addr = 16'(`DM_LOAD_BASE + 4 * k);
        return {4'hD, 4'(p), addr[15:8] ^ addr[7:0], addr};
    endfunction

    function automatic logic [31:0] host_word(input int p, input logic [15:0] addr);
        if (addr < `DM_LOAD_BASE) begin
            return im_tab[p][int'(addr >> 2)];
        end
        return dm_tab[p][int'((addr - `DM_LOAD_BASE) >> 2)];
    endfunction

    task automatic emit(input int p, input logic [31:0] word);
        im_tab[p][im_len[p]] = word;
        im_len[p]++;
    endtask

    task automatic expect_write(input int p, input logic [15:0] addr, input logic [31:0] data);
        wr_addr_tab[p][wr_cnt[p]] = addr;
        wr_data_tab[p][wr_cnt[p]] = data;
        wr_cnt[p]++;
    endtask

    task automatic park(input int p);
        emit(p, imm_word(cpu_pkg::OP_JMP, 4'd0, 4'd0, 16'(4 * im_len[p]))); // jump to self
    endtask

    task automatic build_table();
        logic [31:0] a, b, c, d, e, f, g, h, v;
        for (int p = 0; p < NUM_PROGS; p++) begin
            im_len[p] = 0;
            wr_cnt[p] = 0;
            for (int k = 0; k < `IMEM_WORDS; k++) begin
                im_tab[p][k] = '0;
            end
            for (int k = 0; k < `DMEM_WORDS; k++) begin
                dm_tab[p][k] = fill_word(p, k);
            end
        end
        // dependent chain where each op reads the result just before it
        a = sext16(16'h1234);
        b = a + sext16(16'h0F0F);
        c = a + b;
        d = b - c;
        e = d & c;
        f = e | a;
        g = f ^ d;
        h = g + sext16(16'hFFFD);
        emit(0, imm_word(cpu_pkg::OP_ADDI, 4'd1, 4'd0, 16'h1234));
        emit(0, imm_word(cpu_pkg::OP_ADDI, 4'd2, 4'd1, 16'h0F0F));
        emit(0, alu_word(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
        emit(0, alu_word(cpu_pkg::OP_SUB, 4'd4, 4'd2, 4'd3));
        emit(0, alu_word(cpu_pkg::OP_AND, 4'd5, 4'd4, 4'd3));
        emit(0, alu_word(cpu_pkg::OP_OR, 4'd6, 4'd5, 4'd1));
        emit(0, alu_word(cpu_pkg::OP_XOR, 4'd7, 4'd6, 4'd4));
        emit(0, imm_word(cpu_pkg::OP_ADDI, 4'd8, 4'd7, 16'hFFFD));
        for (int k = 0; k < 6; k++) begin
            emit(0, imm_word(cpu_pkg::OP_ST, 4'(k + 3), 4'd0, host_addr(k)));
        end
        park(0);
        expect_write(0, host_addr(0), c);
        expect_write(0, host_addr(1), d);
        expect_write(0, host_addr(2), e);
        expect_write(0, host_addr(3), f);
        expect_write(0, host_addr(4), g);
        expect_write(0, host_addr(5), h);
        // load, add, local store, reload, mix with a second load
        v = dm_tab[1][2] + sext16(16'h0100);
        emit(1, imm_word(cpu_pkg::OP_LD, 4'd1, 4'd0, 16'd8));
        emit(1, imm_word(cpu_pkg::OP_ADDI, 4'd2, 4'd1, 16'h0100));
        emit(1, imm_word(cpu_pkg::OP_ST, 4'd2, 4'd0, 16'h0040));
        emit(1, imm_word(cpu_pkg::OP_LD, 4'd3, 4'd0, 16'h0040));
        emit(1, imm_word(cpu_pkg::OP_LD, 4'd4, 4'd0, 16'd12));
        emit(1, alu_word(cpu_pkg::OP_XOR, 4'd5, 4'd3, 4'd4));
        emit(1, imm_word(cpu_pkg::OP_ST, 4'd3, 4'd0, host_addr(0)));
        emit(1, imm_word(cpu_pkg::OP_ST, 4'd5, 4'd0, host_addr(1)));
        park(1);
        expect_write(1, host_addr(0), v);
        expect_write(1, host_addr(1), v ^ dm_tab[1][3]);
        // branches compare rs with rd and jump to an absolute byte address
        a = sext16(16'd5);
        b = sext16(16'd5);
        c = sext16(16'd9);
        v = sext16(16'h005A);                                        // marker value
        emit(2, imm_word(cpu_pkg::OP_ADDI, 4'd1, 4'd0, 16'd5));
        emit(2, imm_word(cpu_pkg::OP_ADDI, 4'd2, 4'd0, 16'd5));
        emit(2, imm_word(cpu_pkg::OP_ADDI, 4'd3, 4'd0, 16'd9));
        emit(2, imm_word(cpu_pkg::OP_ADDI, 4'd10, 4'd0, 16'h005A));
        emit(2, imm_word(cpu_pkg::OP_BEQ, 4'd2, 4'd1, 16'd24));       // word 4
        emit(2, imm_word(cpu_pkg::OP_ST, 4'd10, 4'd0, host_addr(0)));
        emit(2, imm_word(cpu_pkg::OP_ST, 4'd10, 4'd0, host_addr(1)));
        emit(2, imm_word(cpu_pkg::OP_BNE, 4'd3, 4'd1, 16'd36));       // word 7
        emit(2, imm_word(cpu_pkg::OP_ST, 4'd10, 4'd0, host_addr(2)));
        emit(2, imm_word(cpu_pkg::OP_BEQ, 4'd3, 4'd1, 16'd44));       // word 9
        emit(2, imm_word(cpu_pkg::OP_ST, 4'd10, 4'd0, host_addr(3)));
        emit(2, imm_word(cpu_pkg::OP_BNE, 4'd2, 4'd1, 16'd52));       // word 11
        emit(2, imm_word(cpu_pkg::OP_ST, 4'd10, 4'd0, host_addr(4)));
        emit(2, imm_word(cpu_pkg::OP_JMP, 4'd0, 4'd0, 16'd60));       // word 13
        emit(2, imm_word(cpu_pkg::OP_ST, 4'd10, 4'd0, host_addr(5)));
        emit(2, imm_word(cpu_pkg::OP_ST, 4'd10, 4'd0, host_addr(6)));
        park(2);
        if (a != b) begin
            expect_write(2, host_addr(0), v);
        end
        expect_write(2, host_addr(1), v);
        if (a == c) begin
            expect_write(2, host_addr(2), v);
        end
        if (a != c) begin
            expect_write(2, host_addr(3), v);
        end
        if (a == b) begin
            expect_write(2, host_addr(4), v);
        end
        expect_write(2, host_addr(6), v);                            // marker 5 is jumped over
        // back to back host stores
        for (int k = 0; k < 8; k++) begin
            emit(3, imm_word(cpu_pkg::OP_ADDI, 4'(k + 1), 4'd0, 16'(16'h1111 * (k + 1))));
        end
        for (int k = 0; k < 8; k++) begin
            emit(3, imm_word(cpu_pkg::OP_ST, 4'(k + 1), 4'd0, host_addr(k)));
            expect_write(3, host_addr(k), sext16(16'(16'h1111 * (k + 1))));
        end
        park(3);
    endtask

    ////////////////////////////////////////
    // host model
    ////////////////////////////////////////
    task automatic apply_reset();
        @(negedge clk);
        rst_n       = 1'b0;
        ready       = 1'b0;
        rd_valid    = 1'b0;
        tx_done     = 1'b0;
        ex_wrt_data = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (op == cpu_pkg::HOST_IDLE)
                else value_error("op", 32'(op), 32'(cpu_pkg::HOST_IDLE));
            assert (ex_addr == '0) else value_error("ex_addr", 32'(ex_addr), 32'h0);
        end
    endtask

    task automatic check_read(input logic [`ADDR_W-1:0] exp_addr);
        assert (op == cpu_pkg::HOST_READ)
            else value_error("op", 32'(op), 32'(cpu_pkg::HOST_READ));
        assert (ex_addr == exp_addr) else value_error("ex_addr", 32'(ex_addr), 32'(exp_addr));
    endtask

    task automatic load_program(input int p);
        logic [`ADDR_W-1:0] exp_addr;
        int                 gap;
        ready = 1'b1;
        @(negedge clk);
        for (int w = 0; w < `IMEM_WORDS + `DMEM_WORDS; w++) begin
            exp_addr = (w < `IMEM_WORDS) ? 16'(4 * w)
                                         : 16'(`DM_LOAD_BASE + 4 * (w - `IMEM_WORDS));
            gap = $urandom % 4;
            repeat (gap) begin
                check_read(exp_addr);
                @(negedge clk);
            end
            check_read(exp_addr);
            rd_valid    = 1'b1;
            ex_wrt_data = host_word(p, ex_addr);
            @(negedge clk);
            rd_valid    = 1'b0;
            ex_wrt_data = '0;
        end
    endtask

    task automatic serve_writes(input int p);
        logic [`ADDR_W-1:0] held_addr;
        logic [`XLEN-1:0]   held_data;
        int                 gap;
        for (int i = 0; i < wr_cnt[p]; i++) begin
            while (op != cpu_pkg::HOST_WRITE) begin
                @(negedge clk);
            end
            assert (ex_addr == wr_addr_tab[p][i])
                else value_error("ex_addr", 32'(ex_addr), 32'(wr_addr_tab[p][i]));
            assert (ex_rd_data == wr_data_tab[p][i])
                else value_error("ex_rd_data", ex_rd_data, wr_data_tab[p][i]);
            held_addr = ex_addr;
            held_data = ex_rd_data;
            gap = $urandom % 6;
            repeat (gap) begin
                @(negedge clk);
                assert (op == cpu_pkg::HOST_WRITE)
                    else value_error("op", 32'(op), 32'(cpu_pkg::HOST_WRITE));
                assert (ex_addr == held_addr)
                    else value_error("ex_addr", 32'(ex_addr), 32'(held_addr));
                assert (ex_rd_data == held_data)
                    else value_error("ex_rd_data", ex_rd_data, held_data);
            end
            tx_done = 1'b1;
            @(negedge clk);
            tx_done = 1'b0;
        end
        // program is parked so nothing more may reach the host
        repeat (40) begin
            @(negedge clk);
            assert (op != cpu_pkg::HOST_WRITE)
                else abort_run("a host write appeared after the last expected store");
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        ready       = 1'b0;
        rd_valid    = 1'b0;
        tx_done     = 1'b0;
        ex_wrt_data = '0;
        void'($urandom(33964));
        build_table();
        for (int p = 0; p < NUM_PROGS; p++) begin
            apply_reset();
            load_program(p);
            serve_writes(p);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
